//--- bench/mem_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_soc_tb;

	import mem_soc_pkg::*;

	localparam int RAND_SEED      = 75985;
	localparam int RSP_WAIT       = 4;
	localparam int REPORT_WAIT    = REPORT_BYTES * FRAME_BITS * CLKS_PER_BIT + 40;
	// about 150 accesses of 5 cycles and three reports of 280, with wide margin.
	localparam int TIMEOUT_CYCLES = 20000;

	logic     clk;
	logic     rst;
	mem_req_t cpu_req;
	logic     report;
	logic     busy;
	mem_rsp_t cpu_rsp;
	logic     txd;

	word_t  model_ram [RAM_WORDS];
	count_t m_inst;
	count_t m_dread;
	count_t m_dwrite;
	addr_t  written_q [$];
	byte_t  byte_q [$];
	int     errors       = 0;
	int     tests_run    = 0;
	int     tests_failed = 0;
	int     cycle_count  = 0;

	mem_soc_top UUT (
		.clk     (clk),
		.rst     (rst),
		.cpu_req (cpu_req),
		.report  (report),
		.busy    (busy),
		.cpu_rsp (cpu_rsp),
		.txd     (txd)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function void note_mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
	endfunction

	// ########################################
	// reference model
	// ########################################

	function automatic word_t rom_expect(input addr_t a);
		logic [9:0] idx;
		idx = a[11:2];
		return ({22'b0, idx} * 32'h9E37_79B1) ^ 32'hA5A5_0000;
	endfunction

	function automatic word_t merge_word(input word_t old, input word_t d, input strobe_t s);
		word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				w[8*b +: 8] = d[8*b +: 8];  // strobed lane takes the new byte.
		end
		return w;
	endfunction

	function automatic int ram_index(input addr_t a);
		addr_t off;
		off = a - DATA_BASE;
		return int'(off[9:2]);  // wraps modulo the RAM size.
	endfunction

	// ########################################
	// stimulus and checks
	// ########################################

	task automatic wait_idle();
		@(negedge clk);
		while (busy)
			@(negedge clk);
	endtask

	task automatic access_check(input logic wr, input addr_t a, input word_t d, input strobe_t s);
		word_t exp;
		int    ri;
		int    waited;
		if (a <= INST_LIMIT) begin
			exp = wr ? '0 : rom_expect(a);
			if (!wr)
				m_inst++;
		end else begin
			ri = ram_index(a);
			if (wr) begin
				exp           = merge_word(model_ram[ri], d, s);
				model_ram[ri] = exp;
				m_dwrite++;
			end else begin
				exp = model_ram[ri];
				m_dread++;
			end
		end
		wait_idle();
		@(posedge clk);
		cpu_req <= '{write: wr, addr: a, wdata: d, strobe: s, valid: 1'b1};
		@(posedge clk);
		cpu_req <= '0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!cpu_rsp.valid && waited < RSP_WAIT);
		if (!cpu_rsp.valid) begin
			$display("no response to the %s of address %h at %0t", wr ? "write" : "read", a, $time);
			errors++;
		end else begin
			assert (cpu_rsp.rdata == exp) else
				note_mismatch($sformatf("%s %h returned %h, expected %h",
					wr ? "write" : "read", a, cpu_rsp.rdata, exp));
		end
	endtask

	task automatic run_report(input bit poke);
		byte_t exp [REPORT_BYTES];
		int    waited;
		exp = '{m_inst[7:0], m_inst[15:8], m_dread[7:0], m_dread[15:8],
			m_dwrite[7:0], m_dwrite[15:8]};
		m_inst   = '0;
		m_dread  = '0;
		m_dwrite = '0;
		byte_q.delete();
		wait_idle();
		@(posedge clk);
		report <= 1'b1;
		@(posedge clk);
		report <= 1'b0;
		@(negedge clk);
		if (!busy) begin
			$display("report pulse before %0t was not accepted", $time);
			errors++;
		end
		if (poke) begin
			// these arrive while busy and must be dropped.
			@(posedge clk);
			cpu_req <= '{write: 1'b1, addr: DATA_BASE, wdata: 32'hDEAD_BEEF, strobe: 4'hF, valid: 1'b1};
			@(posedge clk);
			cpu_req <= '{write: 1'b0, addr: 16'h0000, wdata: '0, strobe: '0, valid: 1'b1};
			report  <= 1'b1;
			@(posedge clk);
			cpu_req <= '0;
			report  <= 1'b0;
		end
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (busy && waited < REPORT_WAIT);
		if (busy) begin
			$display("report still busy after %0d cycles at %0t", waited, $time);
			errors++;
		end else if (byte_q.size() != REPORT_BYTES) begin
			note_mismatch($sformatf("%0d serial bytes when busy fell, expected %0d",
				byte_q.size(), REPORT_BYTES));
		end else begin
			foreach (exp[i])
				assert (byte_q[i] == exp[i]) else
					note_mismatch($sformatf("report byte %0d is %h, expected %h",
						i, byte_q[i], exp[i]));
		end
	endtask

	task automatic end_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name, errors - start_errors);
		end
	endtask

	// 8N1 receiver, sampled near mid-bit.
	initial begin
		byte_t rx;
		forever begin
			@(negedge txd);
			if (!rst) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				if (txd !== 1'b0) begin
					$display("framing error: start bit lost at %0t", $time);
					errors++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					rx[i] = txd;  // lsb first.
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (txd !== 1'b1) begin
					$display("framing error: stop bit low at %0t", $time);
					errors++;
				end
				byte_q.push_back(rx);
			end
		end
	end

	// ########################################
	// protocol checks
	// ########################################

	rsp_busy: assert property (@(posedge clk) disable iff (rst)
		(cpu_req.valid && !busy) |=> (busy && !cpu_rsp.valid))
		else note_mismatch("response or busy wrong one cycle after a request");

	rsp_timing: assert property (@(posedge clk) disable iff (rst)
		(cpu_req.valid && !busy) |-> ##2 (busy && cpu_rsp.valid))
		else note_mismatch("response missing two cycles after a request");

	reset_values: assert property (@(posedge clk)
		rst |=> (!busy && !cpu_rsp.valid && txd))
		else note_mismatch("outputs not at reset values");

	initial begin
		addr_t a;
		int    start;
		cpu_req = '0;
		report  = 1'b0;
		rst     = 1'b1;
		m_inst   = '0;
		m_dread  = '0;
		m_dwrite = '0;
		for (int i = 0; i < RAM_WORDS; i++)
			model_ram[i] = '0;
		void'($urandom(RAND_SEED));
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		start = errors;
		@(negedge clk);
		assert (!busy && !cpu_rsp.valid && txd === 1'b1) else
			note_mismatch($sformatf("after reset busy=%b rsp_valid=%b txd=%b",
				busy, cpu_rsp.valid, txd));
		end_test("reset values", start);

		start = errors;
		repeat (40) begin
			a = addr_t'($urandom_range(0, ROM_WORDS - 1) * 4);
			access_check(1'b0, a, '0, '0);
		end
		end_test("instruction reads", start);

		start = errors;
		repeat (30) begin
			a = addr_t'($urandom_range(32'h1000, 32'hFFFF)) & 16'hFFFC;
			written_q.push_back(a);
			access_check(1'b1, a, word_t'($urandom), strobe_t'($urandom));
		end
		foreach (written_q[i])
			access_check(1'b0, written_q[i], '0, '0);
		repeat (20)
			access_check(1'b0, addr_t'($urandom_range(32'h1000, 32'hFFFF)) & 16'hFFFC, '0, '0);
		end_test("data writes and reads", start);

		start = errors;
		repeat (4) begin
			a = addr_t'($urandom_range(0, ROM_WORDS - 1) * 4);
			access_check(1'b1, a, word_t'($urandom), 4'hF);
			access_check(1'b0, a, '0, '0);
		end
		end_test("instruction region writes", start);

		start = errors;
		run_report(1'b0);
		end_test("access report", start);

		start = errors;
		run_report(1'b1);  // counts were just cleared.
		access_check(1'b0, DATA_BASE, '0, '0);
		access_check(1'b0, 16'h0000, '0, '0);
		run_report(1'b0);
		end_test("report clear and busy lockout", start);

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/access_counter.sv
`timescale 1ns/1ps
`default_nettype none

module access_counter (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             inc_inst,
	input  wire logic             inc_dread,
	input  wire logic             inc_dwrite,
	input  wire logic             snap,
	output mem_soc_pkg::count_set_t counts
);

	import mem_soc_pkg::*;

	count_set_t cnt;

	// sticks at all ones.
	function automatic count_t bump(input count_t c, input logic inc);
		return (inc && c != '1) ? c + 1'b1 : c;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= '0;
			counts <= '0;
		end else if (snap) begin
			counts          <= cnt;
			cnt.inst_reads  <= count_t'(inc_inst);  // same-cycle hit lands after the clear.
			cnt.data_reads  <= count_t'(inc_dread);
			cnt.data_writes <= count_t'(inc_dwrite);
		end else begin
			cnt.inst_reads  <= bump(cnt.inst_reads, inc_inst);
			cnt.data_reads  <= bump(cnt.data_reads, inc_dread);
			cnt.data_writes <= bump(cnt.data_writes, inc_dwrite);
		end
	end

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire mem_soc_pkg::mem_req_t req,
	output mem_soc_pkg::mem_rsp_t      rsp
);

	import mem_soc_pkg::*;

	word_t                mem [RAM_WORDS];
	logic [RAM_WORDS-1:0] written;
	addr_t                offset;
	logic [RAM_AW-1:0]    idx;
	word_t                old_word;
	word_t                merged;
	logic                 rsp_valid;
	word_t                rsp_data;

	// region relative, wraps past the end of the array.
	assign offset   = req.addr - DATA_BASE;
	assign idx      = offset[RAM_AW+1:2];
	assign old_word = written[idx] ? mem[idx] : '0;

	always_comb begin
		merged = old_word;
		for (int b = 0; b < $bits(strobe_t); b++) begin
			if (req.strobe[b])
				merged[8*b +: 8] = req.wdata[8*b +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (req.valid && req.write)
			mem[idx] <= merged;
		if (req.valid)
			rsp_data <= req.write ? merged : old_word;
	end

	// per-word flags make the array read as zero after reset.
	always_ff @(posedge clk) begin
		if (rst) begin
			written   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			if (req.valid && req.write)
				written[idx] <= 1'b1;
			rsp_valid <= req.valid;
		end
	end

	assign rsp = '{valid: rsp_valid, rdata: rsp_data};

endmodule

`default_nettype wire

//--- logic/inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
	input  wire logic               clk,
	input  wire logic               rd,
	input  wire mem_soc_pkg::addr_t addr,
	output mem_soc_pkg::word_t      data
);

	import mem_soc_pkg::*;

	word_t rom [ROM_WORDS];

	// contents come from the package function.
	initial begin
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = rom_word(ROM_AW'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (rd)
			data <= rom[addr[ROM_AW+1:2]];  // word index.
	end

endmodule

`default_nettype wire

//--- logic/mem_soc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_soc_ctrl (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire mem_soc_pkg::mem_req_t   cpu_req,
	input  wire logic                    report,
	output logic                         busy,
	output mem_soc_pkg::mem_rsp_t        cpu_rsp,
	output logic                         rom_rd,
	output mem_soc_pkg::addr_t           rom_addr,
	input  wire mem_soc_pkg::word_t      rom_data,
	output mem_soc_pkg::mem_req_t        ram_req,
	input  wire mem_soc_pkg::mem_rsp_t   ram_rsp,
	output logic                         inc_inst,
	output logic                         inc_dread,
	output logic                         inc_dwrite,
	output logic                         snap,
	input  wire mem_soc_pkg::count_set_t count_set,
	output logic                         tx_push,
	output mem_soc_pkg::byte_t           tx_byte,
	input  wire logic                    tx_credit
);

	import mem_soc_pkg::*;

	mem_req_t            req_q;
	logic                pend_valid;
	logic                pend_rom;
	logic                in_inst;
	ctrl_state_t         state;
	logic [CREDIT_W-1:0] credits;
	logic [IDX_W-1:0]    idx;

	assign busy    = req_q.valid | pend_valid | (state != IDLE);
	assign in_inst = (req_q.addr <= INST_LIMIT);

	// ########################################
	// access path
	// ########################################

	always_ff @(posedge clk) begin
		if (rst) begin
			req_q.valid <= 1'b0;
			pend_valid  <= 1'b0;
			pend_rom    <= 1'b0;
		end else begin
			req_q.valid <= cpu_req.valid & ~busy;  // ignored while busy.
			pend_valid  <= req_q.valid;
			pend_rom    <= rom_rd;
		end
		if (!busy) begin
			req_q.write  <= cpu_req.write;
			req_q.addr   <= cpu_req.addr;
			req_q.wdata  <= cpu_req.wdata;
			req_q.strobe <= cpu_req.strobe;
		end
	end

	assign rom_rd   = req_q.valid & ~req_q.write & in_inst;
	assign rom_addr = req_q.addr;

	always_comb begin
		ram_req       = req_q;
		ram_req.valid = req_q.valid & ~in_inst;
	end

	// instruction-region writes fall through here uncounted.
	assign inc_inst   = rom_rd;
	assign inc_dread  = ram_req.valid & ~req_q.write;
	assign inc_dwrite = ram_req.valid & req_q.write;

	always_comb begin
		cpu_rsp.valid = pend_valid;
		if (pend_rom)
			cpu_rsp.rdata = rom_data;
		else if (ram_rsp.valid)
			cpu_rsp.rdata = ram_rsp.rdata;
		else
			cpu_rsp.rdata = '0;  // dropped rom write.
	end

	// ########################################
	// report path
	// ########################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			idx     <= '0;
			credits <= CREDIT_W'(TX_CREDITS);
		end else begin
			credits <= credits - CREDIT_W'(tx_push) + CREDIT_W'(tx_credit);
			case (state)
				IDLE: begin
					if (report && !busy && !cpu_req.valid)
						state <= SNAP;
				end
				SNAP: begin
					state <= SEND;
					idx   <= '0;
				end
				SEND: begin
					if (tx_push)
						idx <= idx + 1'b1;
					// done once the last frame has handed its credit back.
					if (idx == IDX_W'(REPORT_BYTES) && credits == CREDIT_W'(TX_CREDITS))
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign snap    = (state == SNAP);
	assign tx_push = (state == SEND) && (idx != IDX_W'(REPORT_BYTES)) && (credits != '0);

	always_comb begin
		case (idx)
			3'd0:    tx_byte = count_set.inst_reads[7:0];
			3'd1:    tx_byte = count_set.inst_reads[15:8];
			3'd2:    tx_byte = count_set.data_reads[7:0];
			3'd3:    tx_byte = count_set.data_reads[15:8];
			3'd4:    tx_byte = count_set.data_writes[7:0];
			3'd5:    tx_byte = count_set.data_writes[15:8];
			default: tx_byte = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mem_soc_pkg.sv
`default_nettype none

package mem_soc_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strobe_t;
	typedef logic [15:0] count_t;
	typedef logic [7:0]  byte_t;

	// address map.
	localparam addr_t INST_LIMIT = 16'h0FFC;
	localparam addr_t DATA_BASE  = 16'h1000;
	localparam int    ROM_WORDS  = 1024;
	localparam int    RAM_WORDS  = 256;
	localparam int    ROM_AW     = $clog2(ROM_WORDS);
	localparam int    RAM_AW     = $clog2(RAM_WORDS);

	// serial link and report.
	localparam int CLKS_PER_BIT = 4;
	localparam int FRAME_BITS   = 10;  // start, 8 data, stop.
	localparam int TIMER_W      = $clog2(CLKS_PER_BIT);
	localparam int BITCNT_W     = $clog2(FRAME_BITS);
	localparam int TX_CREDITS   = 2;
	localparam int CREDIT_W     = $clog2(TX_CREDITS + 1);
	localparam int PTR_W        = $clog2(TX_CREDITS);
	localparam int REPORT_BYTES = 6;
	localparam int IDX_W        = $clog2(REPORT_BYTES + 1);

	typedef struct packed {
		logic    write;
		addr_t   addr;
		word_t   wdata;
		strobe_t strobe;
		logic    valid;
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		count_t inst_reads;
		count_t data_reads;
		count_t data_writes;
	} count_set_t;

	typedef enum logic [1:0] {IDLE, SNAP, SEND} ctrl_state_t;

	// instruction store contents, indexed by word.
	function automatic word_t rom_word(input logic [ROM_AW-1:0] idx);
		return (word_t'(idx) * 32'h9E37_79B1) ^ 32'hA5A5_0000;
	endfunction

endpackage

`default_nettype wire

//--- logic/mem_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_soc_top (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire mem_soc_pkg::mem_req_t cpu_req,
	input  wire logic                  report,
	output logic                       busy,
	output mem_soc_pkg::mem_rsp_t      cpu_rsp,
	output logic                       txd
);

	import mem_soc_pkg::*;

	logic       rom_rd;
	addr_t      rom_addr;
	word_t      rom_data;
	mem_req_t   ram_req;
	mem_rsp_t   ram_rsp;
	logic       inc_inst;
	logic       inc_dread;
	logic       inc_dwrite;
	logic       snap;
	count_set_t count_set;
	logic       tx_push;
	byte_t      tx_byte;
	logic       tx_credit;

	mem_soc_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.cpu_req    (cpu_req),
		.report     (report),
		.busy       (busy),
		.cpu_rsp    (cpu_rsp),
		.rom_rd     (rom_rd),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.ram_req    (ram_req),
		.ram_rsp    (ram_rsp),
		.inc_inst   (inc_inst),
		.inc_dread  (inc_dread),
		.inc_dwrite (inc_dwrite),
		.snap       (snap),
		.count_set  (count_set),
		.tx_push    (tx_push),
		.tx_byte    (tx_byte),
		.tx_credit  (tx_credit)
	);

	inst_rom u_inst_rom (
		.clk  (clk),
		.rd   (rom_rd),
		.addr (rom_addr),
		.data (rom_data)
	);

	data_ram u_data_ram (
		.clk (clk),
		.rst (rst),
		.req (ram_req),
		.rsp (ram_rsp)
	);

	access_counter u_counter (
		.clk        (clk),
		.rst        (rst),
		.inc_inst   (inc_inst),
		.inc_dread  (inc_dread),
		.inc_dwrite (inc_dwrite),
		.snap       (snap),
		.counts     (count_set)
	);

	uart_tx u_tx (
		.clk    (clk),
		.rst    (rst),
		.push   (tx_push),
		.din    (tx_byte),
		.credit (tx_credit),
		.txd    (txd)
	);

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               push,
	input  wire mem_soc_pkg::byte_t din,
	output logic                    credit,
	output logic                    txd
);

	import mem_soc_pkg::*;

	byte_t                fifo [TX_CREDITS];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [CREDIT_W-1:0]  fill;
	logic                 active;
	logic [FRAME_BITS-1:0] shift;
	logic [TIMER_W-1:0]   timer;
	logic [BITCNT_W-1:0]  bit_cnt;
	logic                 bit_end;
	logic                 load;

	assign bit_end = active && (timer == TIMER_W'(CLKS_PER_BIT - 1));
	assign load    = !active && (fill != '0);
	assign txd     = shift[0];  // idles high once the stop bit is out.

	always_ff @(posedge clk) begin
		if (push)
			fifo[wr_ptr] <= din;
	end

	// ########################################
	// buffer pointers and serializer
	// ########################################

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			fill    <= '0;
			active  <= 1'b0;
			shift   <= '1;
			timer   <= '0;
			bit_cnt <= '0;
			credit  <= 1'b0;
		end else begin
			credit <= 1'b0;
			fill   <= fill + CREDIT_W'(push) - CREDIT_W'(load);
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (load) begin
				rd_ptr  <= rd_ptr + 1'b1;
				active  <= 1'b1;
				shift   <= {1'b1, fifo[rd_ptr], 1'b0};  // stop, data, start.
				timer   <= '0;
				bit_cnt <= '0;
			end else if (active) begin
				timer <= timer + 1'b1;
				if (bit_end) begin
					timer   <= '0;
					shift   <= {1'b1, shift[FRAME_BITS-1:1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BITCNT_W'(FRAME_BITS - 1)) begin
						active <= 1'b0;
						credit <= 1'b1;  // stop bit done.
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_soc_top.f
logic/mem_soc_pkg.sv
logic/inst_rom.sv
logic/data_ram.sv
logic/access_counter.sv
logic/uart_tx.sv
logic/mem_soc_ctrl.sv
logic/mem_soc_top.sv
bench/mem_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module mem_soc_tb -f mem_soc_top.f -o mem_soc_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/mem_soc_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass line not found"
exit 1
